/* Makefile */
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Test passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the output for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* design/bmem_arbiter.sv */
`timescale 1ns/1ns
`include "mem_bus_macros.svh"

module bmem_arbiter (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   icache_read,
    input  logic [`MEM_BUS_W-1:0]  icache_addr,
    output logic                   icache_ready,
    output mem_bus_pkg::mem_line_t icache_rdata,
    output logic                   icache_rvalid,

    input  logic                   dcache_read,
    input  logic                   dcache_write,
    input  logic [`MEM_BUS_W-1:0]  dcache_addr,
    input  mem_bus_pkg::mem_line_t dcache_wdata,
    output logic                   dcache_ready,
    output mem_bus_pkg::mem_line_t dcache_rdata,
    output logic                   dcache_rvalid,

    output logic [`MEM_BUS_W-1:0]  bmem_addr,
    output logic                   bmem_read,
    output logic                   bmem_write,
    output mem_bus_pkg::mem_line_t bmem_wdata,
    input  logic                   bmem_ready,
    input  logic [`MEM_BUS_W-1:0]  bmem_raddr,
    input  mem_bus_pkg::mem_line_t bmem_rdata,
    input  logic                   bmem_rvalid
);

    logic                   i_pend;
    logic                   i_busy;
    logic [`MEM_BUS_W-1:0]  i_addr_q;
    logic                   d_pend;
    logic                   d_busy;
    logic                   d_is_write;
    logic [`MEM_BUS_W-1:0]  d_addr_q;
    mem_bus_pkg::mem_line_t d_wdata_q;

    logic                   in_flight;
    logic                   owner_write;
    mem_bus_pkg::req_src_t  owner;
    logic [`MEM_BUS_W-1:0]  cur_addr;

    logic issue;
    logic pick_d;
    logic rd_done;
    logic wr_done;
    logic done;

    // dcache wins when both are waiting
    assign pick_d = d_pend;
    assign issue  = bmem_ready && !in_flight && (i_pend || d_pend);

    assign bmem_addr  = pick_d ? d_addr_q : i_addr_q;
    assign bmem_read  = issue && (!pick_d || !d_is_write);
    assign bmem_write = issue && pick_d && d_is_write;
    assign bmem_wdata = d_wdata_q;

    // a write is over once the controller is back in idle
    assign rd_done = in_flight && bmem_rvalid && (bmem_raddr == cur_addr);
    assign wr_done = in_flight && owner_write && bmem_ready;
    assign done    = rd_done || wr_done;

    assign icache_ready  = !i_busy;
    assign dcache_ready  = !d_busy;
    assign icache_rvalid = rd_done && (owner == mem_bus_pkg::SRC_ICACHE);
    assign dcache_rvalid = rd_done && (owner == mem_bus_pkg::SRC_DCACHE);
    assign icache_rdata  = bmem_rdata;
    assign dcache_rdata  = bmem_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            i_pend      <= 1'b0;
            i_busy      <= 1'b0;
            d_pend      <= 1'b0;
            d_busy      <= 1'b0;
            d_is_write  <= 1'b0;
            in_flight   <= 1'b0;
            owner_write <= 1'b0;
            owner       <= mem_bus_pkg::SRC_ICACHE;
        end else begin
            if (done && owner == mem_bus_pkg::SRC_ICACHE) begin
                i_busy <= 1'b0;
            end
            if (done && owner == mem_bus_pkg::SRC_DCACHE) begin
                d_busy <= 1'b0;
            end
            if (issue && !pick_d) begin
                i_pend <= 1'b0;
            end
            if (issue && pick_d) begin
                d_pend <= 1'b0;
            end
            // strobes only arrive while ready, so they never race the clears
            if (icache_read) begin
                i_pend <= 1'b1;
                i_busy <= 1'b1;
            end
            if (dcache_read || dcache_write) begin
                d_pend     <= 1'b1;
                d_busy     <= 1'b1;
                d_is_write <= dcache_write;
            end
            if (issue) begin
                in_flight   <= 1'b1;
                owner_write <= bmem_write;
                owner       <= pick_d ? mem_bus_pkg::SRC_DCACHE : mem_bus_pkg::SRC_ICACHE;
            end else if (done) begin
                in_flight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (icache_read) begin
            i_addr_q <= icache_addr;
        end
        if (dcache_read || dcache_write) begin
            d_addr_q  <= dcache_addr;
            d_wdata_q <= dcache_wdata;
        end
        if (issue) begin
            cur_addr <= bmem_addr;
        end
    end

endmodule

/* design/bus_mem_responder.sv */
`timescale 1ns/1ns
`include "mem_bus_macros.svh"

module bus_mem_responder (
    input  logic                  clk,
    input  logic                  rst,

    input  logic [`MEM_BUS_W-1:0] address_data_bus_c_to_m,
    input  logic                  address_on_c_to_m,
    input  logic                  data_on_c_to_m,
    input  logic                  read_en_c_to_m,
    input  logic                  write_en_c_to_m,

    output logic [`MEM_BUS_W-1:0] address_data_bus_m_to_c,
    output logic                  resp_m_to_c
);

    localparam int WAIT  = `MEM_WAIT;
    localparam int CNT_W = $clog2(WAIT + 1);
    localparam int DEPTH = 1 << `MEM_DEPTH_LOG2;

    mem_bus_pkg::mem_line_t      ram [DEPTH];
    mem_bus_pkg::mem_line_t      wr_line;
    logic [`MEM_DEPTH_LOG2-1:0]  line_addr;
    logic [`MEM_BUS_W-1:0]       low_beat;
    logic                        beat_idx;
    logic [CNT_W-1:0]            wait_cnt;
    logic                        active;
    logic                        answer;

    assign active = address_on_c_to_m || data_on_c_to_m || read_en_c_to_m || write_en_c_to_m;

    // the cycle of a resp still shows the old phase, so skip it
    assign answer = active && !resp_m_to_c && (wait_cnt == CNT_W'(WAIT - 1));

    always_comb begin
        wr_line.beat[0] = low_beat;
        wr_line.beat[1] = address_data_bus_c_to_m;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_m_to_c <= 1'b0;
            wait_cnt    <= '0;
            beat_idx    <= 1'b0;
        end else begin
            resp_m_to_c <= answer;
            if (answer) begin
                wait_cnt <= '0;
            end else if (active && !resp_m_to_c) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            if (answer && address_on_c_to_m) begin
                beat_idx <= 1'b0;
            end else if (answer && data_on_c_to_m) begin
                beat_idx <= !beat_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (answer && address_on_c_to_m) begin
            // line aligned, drop the byte offset
            line_addr <= address_data_bus_c_to_m[3 +: `MEM_DEPTH_LOG2];
        end
        if (answer && data_on_c_to_m && write_en_c_to_m) begin
            if (!beat_idx) begin
                low_beat <= address_data_bus_c_to_m;
            end else begin
                ram[line_addr] <= wr_line;
            end
        end
        if (answer && data_on_c_to_m && read_en_c_to_m) begin
            address_data_bus_m_to_c <= ram[line_addr].beat[beat_idx];
        end
    end

endmodule

/* design/fpga_mem_controller.sv */
`timescale 1ns/1ns
`include "mem_bus_macros.svh"

module fpga_mem_controller (
    input  logic                   clk,
    input  logic                   rst,

    // caches to controller
    input  logic [`MEM_BUS_W-1:0]  bmem_addr,
    input  logic                   bmem_read,
    input  logic                   bmem_write,
    input  mem_bus_pkg::mem_line_t bmem_wdata,

    // controller to caches
    output logic                   bmem_ready,
    output logic [`MEM_BUS_W-1:0]  bmem_raddr,
    output mem_bus_pkg::mem_line_t bmem_rdata,
    output logic                   bmem_rvalid,

    // memory to controller
    input  logic [`MEM_BUS_W-1:0]  address_data_bus_m_to_c,
    input  logic                   resp_m_to_c,

    // controller to memory
    output logic [`MEM_BUS_W-1:0]  address_data_bus_c_to_m,
    output logic                   address_on_c_to_m,
    output logic                   data_on_c_to_m,
    output logic                   read_en_c_to_m,
    output logic                   write_en_c_to_m
);

    typedef enum logic [3:0] {
        IDLE,
        READ_ADDR,
        READ_DATA_1,
        READ_DATA_2,
        READ_DONE,
        WRITE_ADDR,
        WRITE_DATA_1,
        WRITE_DATA_2,
        WRITE_DONE
    } state_t;

    state_t                 state;
    state_t                 state_next;
    mem_bus_pkg::mem_line_t wdata_q;

    always_comb begin
        state_next  = state;
        bmem_ready  = 1'b0;
        bmem_rvalid = 1'b0;
        case (state)
            IDLE: begin
                bmem_ready = 1'b1;
                if (bmem_read) begin
                    state_next = READ_ADDR;
                end else if (bmem_write) begin
                    state_next = WRITE_ADDR;
                end
            end
            READ_ADDR: begin
                if (resp_m_to_c) begin
                    state_next = READ_DATA_1;
                end
            end
            READ_DATA_1: begin
                if (resp_m_to_c) begin
                    state_next = READ_DATA_2;
                end
            end
            READ_DATA_2: begin
                if (resp_m_to_c) begin
                    state_next = READ_DONE;
                end
            end
            READ_DONE: begin
                bmem_rvalid = 1'b1;
                state_next  = IDLE;
            end
            WRITE_ADDR: begin
                if (resp_m_to_c) begin
                    state_next = WRITE_DATA_1;
                end
            end
            WRITE_DATA_1: begin
                if (resp_m_to_c) begin
                    state_next = WRITE_DATA_2;
                end
            end
            WRITE_DATA_2: begin
                if (resp_m_to_c) begin
                    state_next = WRITE_DONE;
                end
            end
            WRITE_DONE: begin
                // memory confirms the line is stored
                if (resp_m_to_c) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // enables follow the state being entered
    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= IDLE;
            address_on_c_to_m <= 1'b0;
            data_on_c_to_m    <= 1'b0;
            read_en_c_to_m    <= 1'b0;
            write_en_c_to_m   <= 1'b0;
        end else begin
            state             <= state_next;
            address_on_c_to_m <= (state_next == READ_ADDR) || (state_next == WRITE_ADDR);
            data_on_c_to_m    <= state_next inside {READ_DATA_1, READ_DATA_2,
                                                    WRITE_DATA_1, WRITE_DATA_2};
            read_en_c_to_m    <= state_next inside {READ_ADDR, READ_DATA_1, READ_DATA_2};
            write_en_c_to_m   <= state_next inside {WRITE_ADDR, WRITE_DATA_1,
                                                    WRITE_DATA_2, WRITE_DONE};
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && (bmem_read || bmem_write)) begin
            bmem_raddr <= bmem_addr;
            wdata_q    <= bmem_wdata;
        end
        // bus word only moves on a phase change, so it holds while waiting
        if (state_next != state) begin
            case (state_next)
                READ_ADDR, WRITE_ADDR: address_data_bus_c_to_m <= bmem_addr;
                WRITE_DATA_1:          address_data_bus_c_to_m <= wdata_q.beat[0];
                WRITE_DATA_2:          address_data_bus_c_to_m <= wdata_q.beat[1];
                default:               address_data_bus_c_to_m <= '0;
            endcase
        end
        if (resp_m_to_c && state == READ_DATA_1) begin
            bmem_rdata.beat[0] <= address_data_bus_m_to_c;
        end
        if (resp_m_to_c && state == READ_DATA_2) begin
            bmem_rdata.beat[1] <= address_data_bus_m_to_c;
        end
    end

endmodule

/* design/mem_bus_macros.svh */
`ifndef MEM_BUS_MACROS_SVH
`define MEM_BUS_MACROS_SVH

// multiplexed address/data bus width
`define MEM_BUS_W 32

// one cache line, moved as two bus beats
`define MEM_LINE_W 64

// responder ram holds 2**N lines
`define MEM_DEPTH_LOG2 8

// idle cycles before each responder answer
`define MEM_WAIT 2

`endif

/* design/mem_bus_pkg.sv */
`include "mem_bus_macros.svh"

package mem_bus_pkg;

    localparam int BEATS = `MEM_LINE_W / `MEM_BUS_W;

    // whole line on the cache side and in the ram,
    // split into bus beats in the controller and responder
    // beat 0 is the low word and goes first
    typedef union packed {
        logic [`MEM_LINE_W-1:0]           line;
        logic [BEATS-1:0][`MEM_BUS_W-1:0] beat;
    } mem_line_t;

    // owner of the transaction in flight
    typedef enum logic {
        SRC_ICACHE,
        SRC_DCACHE
    } req_src_t;

endpackage

/* design/mem_subsystem_top.sv */
`timescale 1ns/1ns
`include "mem_bus_macros.svh"

module mem_subsystem_top (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   icache_read,
    input  logic [`MEM_BUS_W-1:0]  icache_addr,
    output logic                   icache_ready,
    output mem_bus_pkg::mem_line_t icache_rdata,
    output logic                   icache_rvalid,

    input  logic                   dcache_read,
    input  logic                   dcache_write,
    input  logic [`MEM_BUS_W-1:0]  dcache_addr,
    input  mem_bus_pkg::mem_line_t dcache_wdata,
    output logic                   dcache_ready,
    output mem_bus_pkg::mem_line_t dcache_rdata,
    output logic                   dcache_rvalid
);

    logic [`MEM_BUS_W-1:0]  bmem_addr;
    logic                   bmem_read;
    logic                   bmem_write;
    mem_bus_pkg::mem_line_t bmem_wdata;
    logic                   bmem_ready;
    logic [`MEM_BUS_W-1:0]  bmem_raddr;
    mem_bus_pkg::mem_line_t bmem_rdata;
    logic                   bmem_rvalid;

    // multiplexed bus
    logic [`MEM_BUS_W-1:0]  address_data_bus_c_to_m;
    logic                   address_on_c_to_m;
    logic                   data_on_c_to_m;
    logic                   read_en_c_to_m;
    logic                   write_en_c_to_m;
    logic [`MEM_BUS_W-1:0]  address_data_bus_m_to_c;
    logic                   resp_m_to_c;

    bmem_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .icache_read   (icache_read),
        .icache_addr   (icache_addr),
        .icache_ready  (icache_ready),
        .icache_rdata  (icache_rdata),
        .icache_rvalid (icache_rvalid),
        .dcache_read   (dcache_read),
        .dcache_write  (dcache_write),
        .dcache_addr   (dcache_addr),
        .dcache_wdata  (dcache_wdata),
        .dcache_ready  (dcache_ready),
        .dcache_rdata  (dcache_rdata),
        .dcache_rvalid (dcache_rvalid),
        .bmem_addr     (bmem_addr),
        .bmem_read     (bmem_read),
        .bmem_write    (bmem_write),
        .bmem_wdata    (bmem_wdata),
        .bmem_ready    (bmem_ready),
        .bmem_raddr    (bmem_raddr),
        .bmem_rdata    (bmem_rdata),
        .bmem_rvalid   (bmem_rvalid)
    );

    fpga_mem_controller u_controller (
        .clk                     (clk),
        .rst                     (rst),
        .bmem_addr               (bmem_addr),
        .bmem_read               (bmem_read),
        .bmem_write              (bmem_write),
        .bmem_wdata              (bmem_wdata),
        .bmem_ready              (bmem_ready),
        .bmem_raddr              (bmem_raddr),
        .bmem_rdata              (bmem_rdata),
        .bmem_rvalid             (bmem_rvalid),
        .address_data_bus_m_to_c (address_data_bus_m_to_c),
        .resp_m_to_c             (resp_m_to_c),
        .address_data_bus_c_to_m (address_data_bus_c_to_m),
        .address_on_c_to_m       (address_on_c_to_m),
        .data_on_c_to_m          (data_on_c_to_m),
        .read_en_c_to_m          (read_en_c_to_m),
        .write_en_c_to_m         (write_en_c_to_m)
    );

    bus_mem_responder u_responder (
        .clk                     (clk),
        .rst                     (rst),
        .address_data_bus_c_to_m (address_data_bus_c_to_m),
        .address_on_c_to_m       (address_on_c_to_m),
        .data_on_c_to_m          (data_on_c_to_m),
        .read_en_c_to_m          (read_en_c_to_m),
        .write_en_c_to_m         (write_en_c_to_m),
        .address_data_bus_m_to_c (address_data_bus_m_to_c),
        .resp_m_to_c             (resp_m_to_c)
    );

endmodule

/* tests/mem_subsystem_stim.txt */
# columns: op port address data, op W write, R read, P paired read (two lines, I and D)
# for R and P the data column is the line expected back
W D 00000040 a1a2a3a4b1b2b3b4
R D 00000040 a1a2a3a4b1b2b3b4
R I 00000040 a1a2a3a4b1b2b3b4
W D 00000100 0123456789abcdef
W D 00000108 fedcba9876543210
W D 000007f8 13579bdf2468ace0
W D 00000010 deadbeefcafef00d
R D 00000010 deadbeefcafef00d
R D 000007f8 13579bdf2468ace0
R I 00000108 fedcba9876543210
R D 00000100 0123456789abcdef
P I 00000100 0123456789abcdef
P D 00000040 a1a2a3a4b1b2b3b4
P D 00000108 fedcba9876543210
P I 000007f8 13579bdf2468ace0
W D 00000040 55aa55aa0ff00ff0
R I 00000040 55aa55aa0ff00ff0
R D 00000010 deadbeefcafef00d

/* tests/mem_subsystem_tb.sv */
`timescale 1ns/1ns
`include "mem_bus_macros.svh"

module mem_subsystem_tb;

    logic                   clk;
    logic                   rst;
    logic                   icache_read;
    logic [`MEM_BUS_W-1:0]  icache_addr;
    logic                   icache_ready;
    mem_bus_pkg::mem_line_t icache_rdata;
    logic                   icache_rvalid;
    logic                   dcache_read;
    logic                   dcache_write;
    logic [`MEM_BUS_W-1:0]  dcache_addr;
    mem_bus_pkg::mem_line_t dcache_wdata;
    logic                   dcache_ready;
    mem_bus_pkg::mem_line_t dcache_rdata;
    logic                   dcache_rvalid;

    // one entry per operation line of the stim file
    logic [7:0]             op_q[$];
    logic [7:0]             port_q[$];
    logic [`MEM_BUS_W-1:0]  addr_q[$];
    logic [`MEM_LINE_W-1:0] data_q[$];
    int                     stim_count = 0;

    mem_subsystem_top uut (
        .clk           (clk),
        .rst           (rst),
        .icache_read   (icache_read),
        .icache_addr   (icache_addr),
        .icache_ready  (icache_ready),
        .icache_rdata  (icache_rdata),
        .icache_rvalid (icache_rvalid),
        .dcache_read   (dcache_read),
        .dcache_write  (dcache_write),
        .dcache_addr   (dcache_addr),
        .dcache_wdata  (dcache_wdata),
        .dcache_ready  (dcache_ready),
        .dcache_rdata  (dcache_rdata),
        .dcache_rvalid (dcache_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t ns: %s, got %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic write_line(input logic [`MEM_BUS_W-1:0] addr,
                              input logic [`MEM_LINE_W-1:0] data);
        while (!dcache_ready) @(negedge clk);
        dcache_write      = 1'b1;
        dcache_addr       = addr;
        dcache_wdata.line = data;
        @(negedge clk);
        dcache_write = 1'b0;
        check_equal(64'(dcache_ready), 64'd0, "dcache ready right after write strobe");
        // no read data may show up while a write is running
        while (!dcache_ready) begin
            check_equal(64'(icache_rvalid), 64'd0, "icache rvalid during a write");
            check_equal(64'(dcache_rvalid), 64'd0, "dcache rvalid during a write");
            @(negedge clk);
        end
    endtask

    task automatic read_lines(input logic want_i, input logic [`MEM_BUS_W-1:0] addr_i,
                              input logic [`MEM_LINE_W-1:0] exp_i,
                              input logic want_d, input logic [`MEM_BUS_W-1:0] addr_d,
                              input logic [`MEM_LINE_W-1:0] exp_d);
        logic                  got_i;
        logic                  got_d;
        mem_bus_pkg::req_src_t src_i;
        mem_bus_pkg::req_src_t src_d;
        got_i = 1'b0;
        got_d = 1'b0;
        src_i = mem_bus_pkg::SRC_ICACHE;
        src_d = mem_bus_pkg::SRC_DCACHE;
        while ((want_i && !icache_ready) || (want_d && !dcache_ready)) @(negedge clk);
        icache_read = want_i;
        icache_addr = addr_i;
        dcache_read = want_d;
        dcache_addr = addr_d;
        @(negedge clk);
        icache_read = 1'b0;
        dcache_read = 1'b0;
        while ((want_i && !got_i) || (want_d && !got_d)) begin
            if (icache_rvalid) begin
                check_equal(64'(want_i && !got_i), 64'd1,
                            {src_i.name(), " rvalid without a pending read"});
                check_equal(icache_rdata.line, exp_i,
                            $sformatf("%s read data at %h", src_i.name(), addr_i));
                // dcache has priority in a pair
                check_equal(64'(got_d || !want_d), 64'd1,
                            {src_i.name(), " answered before ", src_d.name()});
                got_i = 1'b1;
            end else if (want_i && !got_i) begin
                check_equal(64'(icache_ready), 64'd0,
                            {src_i.name(), " ready while its read is pending"});
            end
            if (dcache_rvalid) begin
                check_equal(64'(want_d && !got_d), 64'd1,
                            {src_d.name(), " rvalid without a pending read"});
                check_equal(dcache_rdata.line, exp_d,
                            $sformatf("%s read data at %h", src_d.name(), addr_d));
                got_d = 1'b1;
            end else if (want_d && !got_d) begin
                check_equal(64'(dcache_ready), 64'd0,
                            {src_d.name(), " ready while its read is pending"});
            end
            @(negedge clk);
        end
        // single cycle pulse, then ready is back
        check_equal(64'(icache_rvalid), 64'd0, {src_i.name(), " rvalid longer than a cycle"});
        check_equal(64'(dcache_rvalid), 64'd0, {src_d.name(), " rvalid longer than a cycle"});
        check_equal(64'(icache_ready), 64'd1, {src_i.name(), " ready after the read"});
        check_equal(64'(dcache_ready), 64'd1, {src_d.name(), " ready after the read"});
    endtask

    initial begin
        int limit;
        wait (stim_count > 0);
        limit = stim_count * 40 * (`MEM_WAIT + 2) + 100;
        repeat (limit) @(posedge clk);
        fail_run($sformatf("watchdog expired after %0d cycles, a transaction never finished",
                           limit));
    end

    initial begin
        int                     fd;
        int                     code;
        int                     c;
        int                     idx;
        int                     pi;
        int                     pd;
        logic [7:0]             op_c;
        logic [7:0]             port_c;
        logic [`MEM_BUS_W-1:0]  addr;
        logic [`MEM_LINE_W-1:0] data;
        logic                   at_end;

        rst               = 1'b1;
        icache_read       = 1'b0;
        icache_addr       = '0;
        dcache_read       = 1'b0;
        dcache_write      = 1'b0;
        dcache_addr       = '0;
        dcache_wdata.line = '0;

        fd = $fopen("tests/mem_subsystem_stim.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the stimulus file tests/mem_subsystem_stim.txt");
        end
        at_end = 1'b0;
        while (!at_end) begin
            code = $fscanf(fd, " %c", op_c);
            if (code != 1) begin
                at_end = 1'b1;
            end else if (op_c == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) c = $fgetc(fd);
            end else begin
                code = $fscanf(fd, " %c %h %h", port_c, addr, data);
                if (code != 3) begin
                    fail_run("malformed line in the stimulus file");
                end
                op_q.push_back(op_c);
                port_q.push_back(port_c);
                addr_q.push_back(addr);
                data_q.push_back(data);
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            fail_run("the stimulus file holds no operations");
        end
        stim_count = op_q.size();

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_equal(64'(icache_ready), 64'd1, "icache ready after reset");
        check_equal(64'(dcache_ready), 64'd1, "dcache ready after reset");
        check_equal(64'(icache_rvalid), 64'd0, "icache rvalid after reset");
        check_equal(64'(dcache_rvalid), 64'd0, "dcache rvalid after reset");

        idx = 0;
        while (idx < stim_count) begin
            case (op_q[idx])
                "W": begin
                    if (port_q[idx] != "D") begin
                        fail_run("only the dcache port can write");
                    end
                    write_line(addr_q[idx], data_q[idx]);
                    idx += 1;
                end
                "R": begin
                    if (port_q[idx] == "I") begin
                        read_lines(1'b1, addr_q[idx], data_q[idx], 1'b0, '0, '0);
                    end else if (port_q[idx] == "D") begin
                        read_lines(1'b0, '0, '0, 1'b1, addr_q[idx], data_q[idx]);
                    end else begin
                        fail_run("read line names an unknown port");
                    end
                    idx += 1;
                end
                "P": begin
                    pi = -1;
                    pd = -1;
                    if (idx + 1 < stim_count && op_q[idx + 1] == "P") begin
                        if (port_q[idx] == "I" && port_q[idx + 1] == "D") begin
                            pi = idx;
                            pd = idx + 1;
                        end else if (port_q[idx] == "D" && port_q[idx + 1] == "I") begin
                            pd = idx;
                            pi = idx + 1;
                        end
                    end
                    if (pi < 0) begin
                        fail_run("a paired read needs an I line and a D line in a row");
                    end else begin
                        read_lines(1'b1, addr_q[pi], data_q[pi],
                                   1'b1, addr_q[pd], data_q[pd]);
                        idx += 2;
                    end
                end
                default: begin
                    fail_run("unknown operation in the stimulus file");
                end
            endcase
        end

        repeat (4) @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+design
design/mem_bus_pkg.sv
design/bmem_arbiter.sv
design/fpga_mem_controller.sv
design/bus_mem_responder.sv
design/mem_subsystem_top.sv
tests/mem_subsystem_tb.sv
